// File: design/trellisPkg.sv
/*
  trellis demodulator shared definitions
  Q1.17 sample type, datapath widths, NCO sine table,
  trial-phase cos/sin table and the common scale/saturate step
*/
`default_nettype none

package trellisPkg;

  // ------------------------------------------------
  // widths
  localparam int SampleW = 18;                   // I/Q, coefs, products after scaling
  localparam int FracW   = 17;                   // Q1.17 fraction bits
  localparam int PhaseW  = 32;                   // nco accumulator
  localparam int LutBits = 6;                    // phase bits into the sine table
  localparam int MaxRot  = 16;                   // widest trial-phase set
  localparam int AccW    = 40;                   // room for a sum of four 36b products
  localparam int SatMax  = 2**(SampleW-1) - 1;
  localparam int SatMin  = -(2**(SampleW-1));

  typedef logic signed [SampleW-1:0] sampleT;

  // ------------------------------------------------
  // full-cycle sine, round(131071*sin(2*pi*n/64))
  localparam sampleT sineLut [2**LutBits] = '{
         0,   12847,   25571,   38048,   50159,   61786,   72819,   83151,
     92681,  101319,  108982,  115594,  121094,  125427,  128553,  130440,
    131071,  130440,  128553,  125427,  121094,  115594,  108982,  101319,
     92681,   83151,   72819,   61786,   50159,   38048,   25571,   12847,
         0,  -12847,  -25571,  -38048,  -50159,  -61786,  -72819,  -83151,
    -92681, -101319, -108982, -115594, -121094, -125427, -128553, -130440,
   -131071, -130440, -128553, -125427, -121094, -115594, -108982, -101319,
    -92681,  -83151,  -72819,  -61786,  -50159,  -38048,  -25571,  -12847
  };

  // trial phases at 2*pi*m/16
  localparam sampleT rotCos [MaxRot] = '{
     131071,  121094,   92681,   50159,       0,  -50159,  -92681, -121094,
    -131071, -121094,  -92681,  -50159,       0,   50159,   92681,  121094
  };
  localparam sampleT rotSin [MaxRot] = '{
          0,   50159,   92681,  121094,  131071,  121094,   92681,   50159,
          0,  -50159,  -92681, -121094, -131071, -121094,  -92681,  -50159
  };

  // drop FracW bits (floor) and clamp into sampleT
  function automatic sampleT satScale(input logic signed [AccW-1:0] acc);
    logic signed [AccW-1:0] shifted;
    shifted = acc >>> FracW;
    if (shifted > SatMax) return sampleT'(SatMax); // clip high
    if (shifted < SatMin) return sampleT'(SatMin); // clip low
    return shifted[SampleW-1:0];
  endfunction

endpackage

`default_nettype wire

// File: design/phaseNco.sv
/*
  carrier NCO
  32b phase accumulator with a loadable frequency word,
  registered cosine/sine from a 64-entry sine table
*/
`timescale 1ns/1ns
`default_nettype none

module phaseNco
  import trellisPkg::*;
(
  input  logic              clk,
  input  logic              arstN,
  input  logic              freqWe,     // load strobe for freqWord
  input  logic [PhaseW-1:0] freqWord,
  output sampleT            cosine,
  output sampleT            sine
);

  // quarter cycle in table steps
  localparam int QuarterIdx = 2**(LutBits-2);

  logic [PhaseW-1:0]  freqReg;          // active frequency word
  logic [PhaseW-1:0]  phase;            // running phase
  logic [LutBits-1:0] sinIdx;
  logic [LutBits-1:0] cosIdx;

  // ------------------------------------------------
  // frequency and phase accumulation

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      freqReg <= '0;
      phase   <= '0;
    end else begin
      if (freqWe) begin
        freqReg <= freqWord;            // used from next clock on
      end
      phase <= phase + freqReg;         // wraps modulo 2^PhaseW
    end
  end

  // ------------------------------------------------
  // table lookup

  assign sinIdx = phase[PhaseW-1 -: LutBits];                // top phase bits
  assign cosIdx = sinIdx + LutBits'(QuarterIdx);             // cos = sin + 90deg, wraps

  // registered outputs, reset value matches phase 0
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      cosine <= sineLut[QuarterIdx];    // unity
      sine   <= sineLut[0];             // zero
    end else begin
      cosine <= sineLut[cosIdx];
      sine   <= sineLut[sinIdx];
    end
  end

  // ------------------------------------------------
  // checks

  // a load must carry a defined word or the whole derotation goes X
  freqWordKnown: assert property (
    @(posedge clk) disable iff (!arstN)
    freqWe |-> !$isunknown(freqWord)
  ) else $error("phaseNco: freqWord unknown during freqWe");

endmodule

`default_nettype wire

// File: design/complexMult.sv
/*
  derotator complex multiplier
  three-stage 18x18 complex product, Q1.17 scaled and saturated,
  symbol strobes delayed alongside
*/
`timescale 1ns/1ns
`default_nettype none

module complexMult
  import trellisPkg::*;
(
  input  logic   clk,
  input  logic   arstN,
  input  sampleT aReal,
  input  sampleT aImag,
  input  sampleT bReal,
  input  sampleT bImag,
  input  logic   sym2xIn,
  input  logic   symIn,
  output sampleT pReal,
  output sampleT pImag,
  output logic   sym2xDly,
  output logic   symDly
);

  localparam int ProdW = 2*SampleW;     // raw partial product
  localparam int Depth = 3;             // data latency in clocks

  logic signed [ProdW-1:0] arBr, aiBi, arBi, aiBr;  // stage 1
  logic signed [AccW-1:0]  sumReal, sumImag;        // stage 2
  logic [Depth-1:0]        sym2xPipe;
  logic [Depth-1:0]        symPipe;

  // ------------------------------------------------
  // datapath, no reset on payload

  always_ff @(posedge clk) begin
    arBr    <= aReal * bReal;           // stage 1 partials
    aiBi    <= aImag * bImag;
    arBi    <= aReal * bImag;
    aiBr    <= aImag * bReal;
    sumReal <= arBr - aiBi;             // stage 2, (a+jb)(c+jd)
    sumImag <= arBi + aiBr;
    pReal   <= satScale(sumReal);       // stage 3 back to Q1.17
    pImag   <= satScale(sumImag);
  end

  // ------------------------------------------------
  // strobe pipe, same depth as the data

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      sym2xPipe <= '0;
      symPipe   <= '0;
    end else begin
      sym2xPipe <= {sym2xPipe[Depth-2:0], sym2xIn};
      symPipe   <= {symPipe[Depth-2:0], symIn};
    end
  end

  assign sym2xDly = sym2xPipe[Depth-1];
  assign symDly   = symPipe[Depth-1];

endmodule

`default_nettype wire

// File: design/matchedFilter.sv
/*
  two-tap complex matched filter
  correlates one symbol's sample pair with a fixed coefficient pair,
  one registered result per symbol
*/
`timescale 1ns/1ns
`default_nettype none

module matchedFilter
  import trellisPkg::*;
#(
  parameter sampleT Coef0Real = '0,     // tap on the newer sample
  parameter sampleT Coef0Imag = '0,
  parameter sampleT Coef1Real = '0,     // tap on the older sample
  parameter sampleT Coef1Imag = '0
) (
  input  logic   clk,
  input  logic   arstN,
  input  logic   sym2xEn,               // sample valid
  input  logic   symEn,                 // second sample of the symbol
  input  sampleT inReal,
  input  sampleT inImag,
  output sampleT outReal,
  output sampleT outImag,
  output logic   filtValid
);

  sampleT                 olderReal;    // first sample of the pair
  sampleT                 olderImag;
  logic signed [AccW-1:0] accReal;
  logic signed [AccW-1:0] accImag;

  // ------------------------------------------------
  // complex MAC, newer tap is the live input

  always_comb begin
    accReal = Coef1Real * olderReal - Coef1Imag * olderImag
            + Coef0Real * inReal    - Coef0Imag * inImag;
    accImag = Coef1Real * olderImag + Coef1Imag * olderReal
            + Coef0Real * inImag    + Coef0Imag * inReal;
  end

  // sample window and result
  always_ff @(posedge clk) begin
    if (sym2xEn) begin
      olderReal <= inReal;              // shifts every sample
      olderImag <= inImag;
    end
    if (symEn) begin
      outReal <= satScale(accReal);     // held until next symbol
      outImag <= satScale(accImag);
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      filtValid <= 1'b0;
    end else begin
      filtValid <= symEn;               // marks the fresh result
    end
  end

  // ------------------------------------------------
  // checks

  // symbol strobe has to land on a sample, else the pair is misaligned
  symOnSample: assert property (
    @(posedge clk) disable iff (!arstN)
    symEn |-> sym2xEn
  ) else $error("matchedFilter: symEn without sym2xEn");

endmodule

`default_nettype wire

// File: design/phaseRotator.sv
/*
  trial-phase rotator
  real part of both filter outputs at NumRot evenly spaced phases,
  i.e. the branch-metric inputs of the Viterbi decoder
*/
`timescale 1ns/1ns
`default_nettype none

module phaseRotator
  import trellisPkg::*;
#(
  parameter int NumRot = 8              // 4, 8 or 16
) (
  input  logic   clk,
  input  logic   arstN,
  input  logic   inEn,                  // filter outputs fresh
  input  sampleT f0Real,
  input  sampleT f0Imag,
  input  sampleT f1Real,
  input  sampleT f1Imag,
  output sampleT out0Real [NumRot],
  output sampleT out1Real [NumRot],
  output logic   rotValid
);

  localparam int RotStep = MaxRot / NumRot;  // table stride per trial phase

  // ------------------------------------------------
  // elaboration check on the phase count

  if (NumRot != 4 && NumRot != 8 && NumRot != 16) begin : gBadNumRot
    $error("phaseRotator: NumRot must be 4, 8 or 16");
  end

  // Re{f * e^-j(2*pi*m/16)}
  function automatic sampleT trialReal(input sampleT fRe, input sampleT fIm, input int m);
    logic signed [AccW-1:0] acc;
    acc = fRe * rotCos[m] + fIm * rotSin[m];
    return satScale(acc);
  endfunction

  // ------------------------------------------------
  // output registers

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      rotValid <= 1'b0;
      for (int k = 0; k < NumRot; k++) begin
        out0Real[k] <= '0;
        out1Real[k] <= '0;
      end
    end else begin
      rotValid <= inEn;                 // one pulse per symbol
      if (inEn) begin
        for (int k = 0; k < NumRot; k++) begin
          out0Real[k] <= trialReal(f0Real, f0Imag, k * RotStep);
          out1Real[k] <= trialReal(f1Real, f1Imag, k * RotStep);
        end
      end
    end
  end

  // ------------------------------------------------
  // checks

  // symbols are at least two samples apart, so a pulse never repeats
  rotValidSingle: assert property (
    @(posedge clk) disable iff (!arstN)
    rotValid |=> !rotValid
  ) else $error("phaseRotator: rotValid high on consecutive cycles");

endmodule

`default_nettype wire

// File: design/trellis.sv
/*
  trellis demodulator front end
  NCO derotation, two complex matched filters per symbol,
  NumRot trial-phase real outputs for branch metrics
*/
`timescale 1ns/1ns
`default_nettype none

module trellis
  import trellisPkg::*;
#(
  parameter int NumRot = 8
) (
  input  logic              clk,
  input  logic              arstN,
  input  sampleT            iIn,
  input  sampleT            qIn,
  input  logic              sym2xEn,    // two per symbol
  input  logic              symEn,      // with the second sym2xEn
  input  logic              freqWe,
  input  logic [PhaseW-1:0] freqWord,
  output sampleT            out0Real [NumRot],
  output sampleT            out1Real [NumRot],
  output logic              rotValid    // 5 clocks after symEn
);

  sampleT cosine, sine;                 // nco -> derotator b operand
  sampleT pReal, pImag;                 // derotated samples
  logic   sym2xDly, symDly;
  sampleT f0Real, f0Imag, f1Real, f1Imag;
  logic   filtValid;

  // ------------------------------------------------
  // carrier removal

  phaseNco nco (
    .clk(clk), .arstN(arstN),
    .freqWe(freqWe), .freqWord(freqWord),
    .cosine(cosine), .sine(sine)
  );

  complexMult derot (
    .clk(clk), .arstN(arstN),
    .aReal(iIn), .aImag(qIn),
    .bReal(cosine), .bImag(sine),
    .sym2xIn(sym2xEn), .symIn(symEn),
    .pReal(pReal), .pImag(pImag),
    .sym2xDly(sym2xDly), .symDly(symDly)
  );

  // ------------------------------------------------
  // matched filters, coef order 0 re, 0 im, 1 re, 1 im

  matchedFilter #(18'sh1B48C, 18'sh10B85, 18'sh3D7D4, 18'sh1FE6B) f0 (
    .clk(clk), .arstN(arstN),
    .sym2xEn(sym2xDly), .symEn(symDly),
    .inReal(pReal), .inImag(pImag),
    .outReal(f0Real), .outImag(f0Imag),
    .filtValid(filtValid)
  );

  matchedFilter #(18'sh1B48C, 18'sh2F47B, 18'sh3D7D4, 18'sh20195) f1 (
    .clk(clk), .arstN(arstN),
    .sym2xEn(sym2xDly), .symEn(symDly),
    .inReal(pReal), .inImag(pImag),
    .outReal(f1Real), .outImag(f1Imag),
    .filtValid()                        // same timing as f0
  );

  // ------------------------------------------------
  // trial phases

  phaseRotator #(.NumRot(NumRot)) rot (
    .clk(clk), .arstN(arstN),
    .inEn(filtValid),
    .f0Real(f0Real), .f0Imag(f0Imag),
    .f1Real(f1Real), .f1Imag(f1Imag),
    .out0Real(out0Real), .out1Real(out1Real),
    .rotValid(rotValid)
  );

endmodule

`default_nettype wire

// File: sim/trellisChecker.sv
/*
  trellis front end result checker
  queues expected rotator outputs, compares them on rotValid,
  checks reset state, phase symmetry and symEn to rotValid latency
*/
`timescale 1ns/1ns
`default_nettype none

module trellisChecker
  import trellisPkg::*;
#(
  parameter int NumRot = 8
) (
  input  logic   clk,
  input  logic   arstN,
  input  logic   symEn,                 // DUT input watched for latency
  input  logic   rotValid,
  input  sampleT out0Real [NumRot],
  input  sampleT out1Real [NumRot],
  input  logic   expPush,               // one expected symbol per pulse
  input  int     expTest,
  input  sampleT exp0 [NumRot],
  input  sampleT exp1 [NumRot],
  input  logic   endRun,
  output logic   pending,               // expected symbols still queued
  output logic   reportDone,
  output int     errorCount
);

  localparam int Latency = 5;           // symEn edge to rotValid edge

  int     testQ[$];
  sampleT exp0Q[$];
  sampleT exp1Q[$];
  logic [Latency-1:0] symHist;          // symEn history with the oldest at the top

  int resetEdges = 0;
  int resetErrs = 0;
  int dataErrs = 0;
  int symmChecks = 0;
  int symmErrs = 0;
  int strobeErrs = 0;
  int symCount = 0;
  int rotCount = 0;
  int valueChecks = 0;
  int curTest = 0;
  int curSyms = 0;
  int curErrs = 0;
  int testsRun = 0;
  int testsFailed = 0;
  bit resetSeen = 0;

  function automatic string testName(input int t);
    case (t)
      1: return "reset state";
      2: return "zero frequency";
      3: return "phase symmetry";
      4: return "fixed derotation";
      5: return "frequency change";
      6: return "strobe count and latency";
      default: return "file test";
    endcase
  endfunction

  task automatic printTestResult(input int num, input int count, input int errs);
    testsRun++;
    if (errs != 0) testsFailed++;
    $display("test %0d %s: %0d checked, %0d errors, %s",
             num, testName(num), count, errs, (errs == 0) ? "ok" : "FAIL");
  endtask

  // close the file test in progress
  task automatic closeTest();
    if (curTest != 0) printTestResult(curTest, curSyms, curErrs);
    curSyms = 0;
    curErrs = 0;
  endtask

  // ------------------------------------------------
  // reset state

  task automatic checkResetState();
    resetEdges++;
    if (resetEdges > 1) begin           // first edge only settles the flops
      if (rotValid !== 1'b0) begin
        $display("mismatch at %0t ns: rotValid expected 0 got %0b", $time, rotValid);
        resetErrs++;
      end
      for (int k = 0; k < NumRot; k++) begin
        if (out0Real[k] !== '0 || out1Real[k] !== '0) begin
          $display("mismatch at %0t ns: out0Real/out1Real[%0d] expected 0 got %0d/%0d",
                   $time, k, out0Real[k], out1Real[k]);
          resetErrs++;
        end
      end
    end
  endtask

  // ------------------------------------------------
  // one rotator result against the queue

  task automatic checkSymmetry(input sampleT v [NumRot], input string sigName);
    int sum;
    for (int k = 0; k < NumRot/2; k++) begin
      symmChecks++;
      sum = int'(v[k]) + int'(v[k + NumRot/2]);   // opposite phases cancel
      if (sum < -1 || sum > 1) begin
        $display("at %0t ns %s[%0d]=%0d and %s[%0d]=%0d are not opposite",
                 $time, sigName, k, v[k], sigName, k + NumRot/2, v[k + NumRot/2]);
        symmErrs++;
      end
    end
  endtask

  task automatic compareSymbol();
    int t;
    sampleT e0;
    sampleT e1;
    if (testQ.size() == 0) begin
      $display("at %0t ns rotValid pulsed with no expected symbol queued", $time);
      dataErrs++;
    end else begin
      t = testQ.pop_front();
      if (t != curTest) begin
        closeTest();
        curTest = t;
      end
      curSyms++;
      for (int k = 0; k < NumRot; k++) begin
        e0 = exp0Q.pop_front();
        e1 = exp1Q.pop_front();
        valueChecks += 2;
        if (out0Real[k] !== e0) begin
          $display("mismatch at %0t ns: out0Real[%0d] expected %0d got %0d",
                   $time, k, e0, out0Real[k]);
          curErrs++;
          dataErrs++;
        end
        if (out1Real[k] !== e1) begin
          $display("mismatch at %0t ns: out1Real[%0d] expected %0d got %0d",
                   $time, k, e1, out1Real[k]);
          curErrs++;
          dataErrs++;
        end
      end
    end
    checkSymmetry(out0Real, "out0Real");
    checkSymmetry(out1Real, "out1Real");
  endtask

  // ------------------------------------------------
  // closing report

  task automatic finalReport();
    closeTest();
    printTestResult(3, symmChecks, symmErrs);
    if (symCount != rotCount) begin
      $display("%0d symEn strobes but %0d rotValid pulses", symCount, rotCount);
      strobeErrs++;
    end
    printTestResult(6, rotCount, strobeErrs);
    errorCount = resetErrs + dataErrs + symmErrs + strobeErrs;
    $display("tests %0d, failed %0d, value checks %0d, errors %0d",
             testsRun, testsFailed, valueChecks, errorCount);
    reportDone = 1'b1;
  endtask

  always @(posedge clk) begin : watch
    if (!arstN) begin
      checkResetState();
      symHist = '0;
      reportDone = 1'b0;
      errorCount = 0;
    end else begin
      if (!resetSeen) begin
        checkResetState();              // right after release
        resetSeen = 1;
        printTestResult(1, resetEdges - 1, resetErrs);
      end
      if (expPush) begin
        testQ.push_back(expTest);
        for (int k = 0; k < NumRot; k++) begin
          exp0Q.push_back(exp0[k]);
          exp1Q.push_back(exp1[k]);
        end
      end
      if (rotValid !== symHist[Latency-1]) begin   // pulse exactly 5 edges on
        $display("mismatch at %0t ns: rotValid expected %0b got %0b",
                 $time, symHist[Latency-1], rotValid);
        strobeErrs++;
      end
      if (symEn) symCount++;
      if (rotValid) begin
        rotCount++;
        compareSymbol();
      end
      symHist = {symHist[Latency-2:0], symEn};
      if (endRun) finalReport();
    end
    pending = (testQ.size() != 0);
  end

endmodule

`default_nettype wire

// File: sim/trellisTb.sv
/*
  trellis front end testbench
  streams symbols from the stimulus file into the DUT,
  hands expected outputs to the checker, bounds the run
*/
`timescale 1ns/1ns
`default_nettype none

module trellisTb
  import trellisPkg::*;
();

  localparam int NumRot = 8;
  localparam int MaxRec = 64;           // stimulus records held

  logic              clk;
  logic              arstN;
  sampleT            iIn, qIn;
  logic              sym2xEn, symEn;
  logic              freqWe;
  logic [PhaseW-1:0] freqWord;
  sampleT            out0Real [NumRot];
  sampleT            out1Real [NumRot];
  logic              rotValid;

  logic   expPush, endRun, pending, reportDone;
  int     expTest, errorCount;
  sampleT exp0 [NumRot];
  sampleT exp1 [NumRot];

  // stimulus records
  int          recCount = 0;
  int          recTest [MaxRec];
  logic        recWe [MaxRec];
  logic [31:0] recWord [MaxRec];
  int          recIA [MaxRec], recQA [MaxRec], recIB [MaxRec], recQB [MaxRec];
  int          recExp0 [MaxRec][NumRot];
  int          recExp1 [MaxRec][NumRot];

  int cycleCount = 0;
  int cycleLimit = 0;

  trellis #(.NumRot(NumRot)) UUT (
    .clk(clk), .arstN(arstN),
    .iIn(iIn), .qIn(qIn),
    .sym2xEn(sym2xEn), .symEn(symEn),
    .freqWe(freqWe), .freqWord(freqWord),
    .out0Real(out0Real), .out1Real(out1Real),
    .rotValid(rotValid)
  );

  trellisChecker #(.NumRot(NumRot)) resultCheck (
    .clk(clk), .arstN(arstN), .symEn(symEn), .rotValid(rotValid),
    .out0Real(out0Real), .out1Real(out1Real),
    .expPush(expPush), .expTest(expTest), .exp0(exp0), .exp1(exp1),
    .endRun(endRun), .pending(pending), .reportDone(reportDone),
    .errorCount(errorCount)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;             // 20 ns period
  end

  // run bound from the record count
  always @(posedge clk) begin
    cycleCount++;
    if (cycleLimit > 0 && cycleCount > cycleLimit) begin
      $display("timeout after %0d cycles, DUT results still outstanding", cycleCount);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // ------------------------------------------------
  // the file has two header lines and 23 fields per record

  task automatic readStimulus();
    int fd, code, val;
    string hdr;
    fd = $fopen("sim/trellis_stimulus.txt", "r");
    if (fd != 0) begin
      code = $fgets(hdr, fd);
      code = $fgets(hdr, fd);
      code = $fscanf(fd, "%d", val);
      while (code == 1 && recCount < MaxRec) begin
        recTest[recCount] = val;
        code = $fscanf(fd, "%d", val);
        recWe[recCount] = (val != 0);
        code = $fscanf(fd, "%h", recWord[recCount]);
        code = $fscanf(fd, "%d %d %d %d", recIA[recCount], recQA[recCount],
                       recIB[recCount], recQB[recCount]);
        for (int k = 0; k < NumRot; k++) code = $fscanf(fd, "%d", recExp0[recCount][k]);
        for (int k = 0; k < NumRot; k++) code = $fscanf(fd, "%d", recExp1[recCount][k]);
        recCount++;
        code = $fscanf(fd, "%d", val);
      end
      $fclose(fd);
    end
  endtask

  // ------------------------------------------------
  // one symbol slot of 4 clocks with the freq load in the second

  task automatic driveRecord(input int r);
    @(posedge clk);
    #2;
    iIn     = sampleT'(recIA[r]);       // older sample
    qIn     = sampleT'(recQA[r]);
    sym2xEn = 1'b1;
    expPush = 1'b1;
    expTest = recTest[r];
    for (int k = 0; k < NumRot; k++) begin
      exp0[k] = sampleT'(recExp0[r][k]);
      exp1[k] = sampleT'(recExp1[r][k]);
    end
    @(posedge clk);
    #2;
    iIn      = '0;
    qIn      = '0;
    sym2xEn  = 1'b0;
    expPush  = 1'b0;
    freqWe   = recWe[r];
    freqWord = recWord[r];
    @(posedge clk);
    #2;
    freqWe  = 1'b0;
    iIn     = sampleT'(recIB[r]);       // newer sample closes the symbol
    qIn     = sampleT'(recQB[r]);
    sym2xEn = 1'b1;
    symEn   = 1'b1;
    @(posedge clk);
    #2;
    iIn     = '0;
    qIn     = '0;
    sym2xEn = 1'b0;
    symEn   = 1'b0;
  endtask

  initial begin : stimulus
    arstN    = 1'b0;
    iIn      = '0;
    qIn      = '0;
    sym2xEn  = 1'b0;
    symEn    = 1'b0;
    freqWe   = 1'b0;
    freqWord = '0;
    expPush  = 1'b0;
    expTest  = 0;
    endRun   = 1'b0;
    for (int k = 0; k < NumRot; k++) begin
      exp0[k] = '0;
      exp1[k] = '0;
    end
    readStimulus();
    cycleLimit = recCount * 4 + 50;
    if (recCount == 0) begin
      $display("no stimulus records read from sim/trellis_stimulus.txt");
      $display("*** TEST FAILED ***");
      $finish;
    end else begin
      repeat (3) @(posedge clk);
      #2;
      arstN = 1'b1;
      for (int r = 0; r < recCount; r++) driveRecord(r);
      @(posedge clk);
      #2;
      while (pending) begin             // last symbols still in the pipe
        @(posedge clk);
        #2;
      end
      endRun = 1'b1;
      @(posedge clk);
      #2;
      endRun = 1'b0;
      while (!reportDone) begin
        @(posedge clk);
        #2;
      end
      if (errorCount == 0) begin
        $display("*** TEST PASSED ***");
      end else begin
        $display("*** TEST FAILED ***");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: sim/trellis_stimulus.txt
# record: test freqWe freqWord(hex) iA qA iB qB, then out0Real[0..7], then out1Real[0..7]
# A is the older sample of the symbol, B the newer one, freqWord loads between them
2 0 00000000 0 0 65537 0
55877 63723 34241 -15299 -55878 -63724 -34242 15298
55877 15298 -34243 -63725 -55878 -15299 34242 63724
2 0 00000000 0 32769 0 0
-32667 -24917 -2571 21280 32666 24916 2570 -21281
32665 21280 -2571 -24917 -32666 -21281 2570 24916
4 1 80000000 0 0 0 0
0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0
4 0 00000000 0 0 -65537 0
55877 63723 34241 -15299 -55878 -63724 -34242 15298
55877 15298 -34243 -63725 -55878 -15299 34242 63724
4 0 00000000 0 -32769 0 0
-32667 -24917 -2571 21280 32666 24916 2570 -21281
32665 21280 -2571 -24917 -32666 -21281 2570 24916
5 1 40000000 0 0 0 0
0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0
5 0 00000000 32769 0 0 0
-32667 -24917 -2571 21280 32666 24916 2570 -21281
32665 21280 -2571 -24917 -32666 -21281 2570 24916
5 0 00000000 0 0 0 65537
55877 63723 34241 -15299 -55878 -63724 -34242 15298
55877 15298 -34243 -63725 -55878 -15299 34242 63724

// File: compile.f
design/trellisPkg.sv
design/phaseNco.sv
design/complexMult.sv
design/matchedFilter.sv
design/phaseRotator.sv
design/trellis.sv
sim/trellisChecker.sv
sim/trellisTb.sv

// File: run.sh
#!/bin/sh
# build and run the trellis front end simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f compile.f --top-module trellisTb -o trellisSim

./obj_dir/trellisSim > sim.log 2>&1
cat sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
  exit 1
fi
exit 0
